// File: Bender.yml
package:
  name: cx_unit

sources:
  - common/cx_pkg.sv
  - common/cx_status_if.sv
  - hw/cx_unit/cx_issue.sv
  - hw/cx_unit/cx_csr.sv
  - hw/cx_unit_top.sv
  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/tb_cx_unit.sv

// File: common/cx_pkg.sv
// Widths, CSR addresses and encodings shared by the CX request path.
// The selector holds three CX_ID_W fields packed from bit 0 upward.

package cx_pkg;

  // Datapath widths
  localparam int unsigned XLEN        = 32;
  localparam int unsigned CX_FUNC_W   = 25;
  localparam int unsigned CX_ID_W     = 2;
  localparam int unsigned CX_STATUS_W = 4;
  localparam int unsigned CSR_ADDR_W  = 12;

  // CXU id, state id and virtual state id side by side
  localparam int unsigned CSR_SEL_W = 3 * CX_ID_W;

  ////////////////////////////////////////////////////////////////////////////
  // CSR map
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [CSR_ADDR_W-1:0] CSR_MCX_SELECTOR = 12'h7C0;
  localparam logic [CSR_ADDR_W-1:0] CSR_MCX_STATUS   = 12'h7C1;

  // Response status bit positions in the response and the status CSR
  localparam int unsigned STATUS_CI_BIT = 0;
  localparam int unsigned STATUS_SI_BIT = 1;
  localparam int unsigned STATUS_FI_BIT = 2;
  localparam int unsigned STATUS_OP_BIT = 3;

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    CSR_READ  = 2'b00,
    CSR_WRITE = 2'b01,
    CSR_SET   = 2'b10,
    CSR_CLEAR = 2'b11
  } csr_op_e;

  // Request FSM states for one outstanding request
  typedef enum logic [1:0] {
    NO_REQ      = 2'b00,
    AWAIT_READY = 2'b01,
    AWAIT_RESP  = 2'b10
  } cx_req_state_e;

endpackage

// File: common/cx_status_if.sv
// Response status from issue logic to the CSR block.
// Flags are only meaningful in the cycle where done is high.

`timescale 1ns/1ps

interface cx_status_if;

  // High for the single cycle a response is accepted
  logic done;

  // Status flags of that response
  logic ci;
  logic si;
  logic fi;
  logic op;

  modport issue (
    output done, ci, si, fi, op
  );

  modport csr (
    input done, ci, si, fi, op
  );

endinterface

// File: flist.f
common/cx_pkg.sv
common/cx_status_if.sv
hw/cx_unit/cx_issue.sv
hw/cx_unit/cx_csr.sv
hw/cx_unit_top.sv
test/tb_clk_gen.sv
test/tb_cx_unit.sv

// File: hw/cx_unit/cx_csr.sv
// MCX selector and sticky MCX status CSRs.
// Reads are combinational; unknown addresses read zero and ignore writes.

`timescale 1ns/1ps

module cx_csr (
  input  logic                          clk_i,
  input  logic                          rst_ni,

  // CSR access port
  input  logic                          csr_access_i,
  input  cx_pkg::csr_op_e               csr_op_i,
  input  logic [cx_pkg::CSR_ADDR_W-1:0] csr_addr_i,
  input  logic [cx_pkg::XLEN-1:0]       csr_wdata_i,
  output logic [cx_pkg::XLEN-1:0]       csr_rdata_o,

  cx_status_if.csr                      status_i,

  // Selector fields toward the CXU
  output logic [cx_pkg::CX_ID_W-1:0]    cx_cxu_id_o,
  output logic [cx_pkg::CX_ID_W-1:0]    cx_state_id_o,
  output logic [cx_pkg::CX_ID_W-1:0]    cx_virt_state_id_o
);

  logic [cx_pkg::CSR_SEL_W-1:0]   selector_q, selector_d;
  logic [cx_pkg::CX_STATUS_W-1:0] status_q, status_d;
  logic [cx_pkg::CX_STATUS_W-1:0] resp_flags;

  logic [cx_pkg::XLEN-1:0]        selector_ext;
  logic [cx_pkg::XLEN-1:0]        status_ext;
  logic [cx_pkg::XLEN-1:0]        selector_upd;
  logic [cx_pkg::XLEN-1:0]        status_upd;

  logic                           sel_hit;
  logic                           stat_hit;

  // Read, write, set or clear applied to a full-width register value
  function automatic logic [cx_pkg::XLEN-1:0] csr_apply(
    input cx_pkg::csr_op_e         op,
    input logic [cx_pkg::XLEN-1:0] old_val,
    input logic [cx_pkg::XLEN-1:0] wval
  );
    logic [cx_pkg::XLEN-1:0] res;
    unique case (op)
      cx_pkg::CSR_WRITE: res = wval;
      cx_pkg::CSR_SET:   res = old_val | wval;
      cx_pkg::CSR_CLEAR: res = old_val & ~wval;
      default:           res = old_val;
    endcase
    return res;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Decode and read
  ////////////////////////////////////////////////////////////////////////////

  assign sel_hit  = csr_access_i && (csr_addr_i == cx_pkg::CSR_MCX_SELECTOR);
  assign stat_hit = csr_access_i && (csr_addr_i == cx_pkg::CSR_MCX_STATUS);

  always_comb begin
    selector_ext = '0;
    status_ext   = '0;
    selector_ext[cx_pkg::CSR_SEL_W-1:0] = selector_q;
    status_ext[cx_pkg::CX_STATUS_W-1:0] = status_q;
  end

  // Read data is the register value before this cycle's update
  always_comb begin
    csr_rdata_o = '0;
    if (sel_hit) csr_rdata_o = selector_ext;
    if (stat_hit) csr_rdata_o = status_ext;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Update
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    resp_flags = '0;
    resp_flags[cx_pkg::STATUS_CI_BIT] = status_i.ci;
    resp_flags[cx_pkg::STATUS_SI_BIT] = status_i.si;
    resp_flags[cx_pkg::STATUS_FI_BIT] = status_i.fi;
    resp_flags[cx_pkg::STATUS_OP_BIT] = status_i.op;
  end

  assign selector_upd = csr_apply(csr_op_i, selector_ext, csr_wdata_i);
  assign status_upd   = csr_apply(csr_op_i, status_ext, csr_wdata_i);

  // CSR op is applied first and the response flags are ORed on top
  always_comb begin
    selector_d = sel_hit ? selector_upd[cx_pkg::CSR_SEL_W-1:0] : selector_q;
    status_d   = stat_hit ? status_upd[cx_pkg::CX_STATUS_W-1:0] : status_q;
    if (status_i.done) status_d = status_d | resp_flags;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      selector_q <= '0;
      status_q   <= '0;
    end else begin
      selector_q <= selector_d;
      status_q   <= status_d;
    end
  end

  assign cx_cxu_id_o        = selector_q[cx_pkg::CX_ID_W-1:0];
  assign cx_state_id_o      = selector_q[2*cx_pkg::CX_ID_W-1:cx_pkg::CX_ID_W];
  assign cx_virt_state_id_o = selector_q[3*cx_pkg::CX_ID_W-1:2*cx_pkg::CX_ID_W];

  a_csr_op_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    csr_access_i |-> !$isunknown(csr_op_i))
    else $error("CSR access with unknown op");

endmodule

// File: hw/cx_unit/cx_issue.sv
// Issues one latched command at a time to the CXU over valid/ready.
// The result pulses for one cycle and has no back-pressure.

`timescale 1ns/1ps

module cx_issue (
  input  logic                         clk_i,
  input  logic                         rst_ni,

  // Command side
  input  logic                         cmd_valid_i,
  output logic                         cmd_ready_o,
  input  logic [cx_pkg::CX_FUNC_W-1:0] cmd_func_i,
  input  logic [cx_pkg::XLEN-1:0]      cmd_data0_i,
  input  logic [cx_pkg::XLEN-1:0]      cmd_data1_i,

  // CXU request
  output logic                         cx_req_valid_o,
  input  logic                         cx_req_ready_i,
  output logic [cx_pkg::CX_FUNC_W-1:0] cx_func_o,
  output logic [cx_pkg::XLEN-1:0]      cx_req_data0_o,
  output logic [cx_pkg::XLEN-1:0]      cx_req_data1_o,

  // CXU response
  input  logic                           cx_resp_valid_i,
  output logic                           cx_resp_ready_o,
  input  logic [cx_pkg::CX_STATUS_W-1:0] cx_resp_status_i,
  input  logic [cx_pkg::XLEN-1:0]        cx_resp_data_i,

  // Result
  output logic                         result_valid_o,
  output logic [cx_pkg::XLEN-1:0]      result_data_o,

  output logic                         busy_o,

  cx_status_if.issue                   status_o
);

  cx_pkg::cx_req_state_e state_q, state_d;

  logic                         cmd_accept;
  logic                         resp_accept;

  logic [cx_pkg::CX_FUNC_W-1:0] func_q;
  logic [cx_pkg::XLEN-1:0]      data0_q;
  logic [cx_pkg::XLEN-1:0]      data1_q;
  logic [cx_pkg::XLEN-1:0]      result_q;
  logic                         result_valid_q;

  ////////////////////////////////////////////////////////////////////////////
  // Request FSM
  ////////////////////////////////////////////////////////////////////////////

  assign cmd_ready_o     = (state_q == cx_pkg::NO_REQ);
  assign cx_req_valid_o  = (state_q == cx_pkg::AWAIT_READY);
  assign cx_resp_ready_o = (state_q == cx_pkg::AWAIT_RESP);
  assign busy_o          = (state_q != cx_pkg::NO_REQ);

  assign cmd_accept  = cmd_valid_i & cmd_ready_o;
  assign resp_accept = cx_resp_valid_i & cx_resp_ready_o;

  // Every command is registered and then waits in AWAIT_READY
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      cx_pkg::NO_REQ: begin
        if (cmd_valid_i) state_d = cx_pkg::AWAIT_READY;
      end
      cx_pkg::AWAIT_READY: begin
        if (cx_req_ready_i) state_d = cx_pkg::AWAIT_RESP;
      end
      cx_pkg::AWAIT_RESP: begin
        if (cx_resp_valid_i) state_d = cx_pkg::NO_REQ;
      end
      default: state_d = cx_pkg::NO_REQ;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= cx_pkg::NO_REQ;
      result_valid_q <= 1'b0;
    end else begin
      state_q        <= state_d;
      result_valid_q <= resp_accept;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Payload and result
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (cmd_accept) begin
      func_q  <= cmd_func_i;
      data0_q <= cmd_data0_i;
      data1_q <= cmd_data1_i;
    end
    if (resp_accept) begin
      result_q <= cx_resp_data_i;
    end
  end

  assign cx_func_o      = func_q;
  assign cx_req_data0_o = data0_q;
  assign cx_req_data1_o = data1_q;
  assign result_valid_o = result_valid_q;
  assign result_data_o  = result_q;

  // Status flags go to the CSR block in the acceptance cycle
  assign status_o.done = resp_accept;
  assign status_o.ci   = cx_resp_status_i[cx_pkg::STATUS_CI_BIT];
  assign status_o.si   = cx_resp_status_i[cx_pkg::STATUS_SI_BIT];
  assign status_o.fi   = cx_resp_status_i[cx_pkg::STATUS_FI_BIT];
  assign status_o.op   = cx_resp_status_i[cx_pkg::STATUS_OP_BIT];

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  // Pending request holds valid and payload until the CXU takes it
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cx_req_valid_o && !cx_req_ready_i) |=>
      (cx_req_valid_o && $stable({cx_func_o, cx_req_data0_o, cx_req_data1_o})))
    else $error("CX request dropped or changed while waiting for ready");

  a_state_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {cx_pkg::NO_REQ, cx_pkg::AWAIT_READY, cx_pkg::AWAIT_RESP})
    else $error("CX request FSM in illegal state");

endmodule

// File: hw/cx_unit_top.sv
// CX request path with its selector and status CSRs.
// One command in flight; the result must be taken in its pulse cycle.

`timescale 1ns/1ps

module cx_unit_top (
  input  logic                           clk_i,
  input  logic                           rst_ni,

  // Command
  input  logic                           cmd_valid_i,
  output logic                           cmd_ready_o,
  input  logic [cx_pkg::CX_FUNC_W-1:0]   cmd_func_i,
  input  logic [cx_pkg::XLEN-1:0]        cmd_data0_i,
  input  logic [cx_pkg::XLEN-1:0]        cmd_data1_i,

  // Result
  output logic                           result_valid_o,
  output logic [cx_pkg::XLEN-1:0]        result_data_o,

  // CXU request
  output logic                           cx_req_valid_o,
  input  logic                           cx_req_ready_i,
  output logic [cx_pkg::CX_FUNC_W-1:0]   cx_func_o,
  output logic [cx_pkg::XLEN-1:0]        cx_req_data0_o,
  output logic [cx_pkg::XLEN-1:0]        cx_req_data1_o,
  output logic [cx_pkg::CX_ID_W-1:0]     cx_cxu_id_o,
  output logic [cx_pkg::CX_ID_W-1:0]     cx_state_id_o,
  output logic [cx_pkg::CX_ID_W-1:0]     cx_virt_state_id_o,

  // CXU response
  input  logic                           cx_resp_valid_i,
  output logic                           cx_resp_ready_o,
  input  logic [cx_pkg::CX_STATUS_W-1:0] cx_resp_status_i,
  input  logic [cx_pkg::XLEN-1:0]        cx_resp_data_i,

  // CSR port
  input  logic                           csr_access_i,
  input  cx_pkg::csr_op_e                csr_op_i,
  input  logic [cx_pkg::CSR_ADDR_W-1:0]  csr_addr_i,
  input  logic [cx_pkg::XLEN-1:0]        csr_wdata_i,
  output logic [cx_pkg::XLEN-1:0]        csr_rdata_o,

  output logic                           busy_o
);

  cx_status_if status_if ();

  cx_issue u_issue (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .cmd_valid_i      (cmd_valid_i),
    .cmd_ready_o      (cmd_ready_o),
    .cmd_func_i       (cmd_func_i),
    .cmd_data0_i      (cmd_data0_i),
    .cmd_data1_i      (cmd_data1_i),
    .cx_req_valid_o   (cx_req_valid_o),
    .cx_req_ready_i   (cx_req_ready_i),
    .cx_func_o        (cx_func_o),
    .cx_req_data0_o   (cx_req_data0_o),
    .cx_req_data1_o   (cx_req_data1_o),
    .cx_resp_valid_i  (cx_resp_valid_i),
    .cx_resp_ready_o  (cx_resp_ready_o),
    .cx_resp_status_i (cx_resp_status_i),
    .cx_resp_data_i   (cx_resp_data_i),
    .result_valid_o   (result_valid_o),
    .result_data_o    (result_data_o),
    .busy_o           (busy_o),
    .status_o         (status_if.issue)
  );

  cx_csr u_csr (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .csr_access_i       (csr_access_i),
    .csr_op_i           (csr_op_i),
    .csr_addr_i         (csr_addr_i),
    .csr_wdata_i        (csr_wdata_i),
    .csr_rdata_o        (csr_rdata_o),
    .status_i           (status_if.csr),
    .cx_cxu_id_o        (cx_cxu_id_o),
    .cx_state_id_o      (cx_state_id_o),
    .cx_virt_state_id_o (cx_virt_state_id_o)
  );

endmodule

// File: test/tb_clk_gen.sv
// Free-running testbench clock of 8 ns and an active-low reset.
// Reset is released on a rising edge after 4 clock cycles.

`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int RST_CYCLES = 4;

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

// File: test/tb_cx_unit.sv
// Table-driven testbench for cx_unit_top with a simple CXU responder.
// The responder answers with op0 + op1 + func; a delay of 0xFF is random.

`timescale 1ns/1ps

module tb_cx_unit;

  localparam int TIMEOUT = 100;

  typedef struct packed {
    bit                            is_csr;
    logic [cx_pkg::CX_FUNC_W-1:0]  func;
    logic [cx_pkg::XLEN-1:0]       d0;
    logic [cx_pkg::XLEN-1:0]       d1;
    logic [cx_pkg::CX_STATUS_W-1:0] status;
    int                            req_dly;
    int                            resp_dly;
    cx_pkg::csr_op_e               op;
    logic [cx_pkg::CSR_ADDR_W-1:0] addr;
    logic [cx_pkg::XLEN-1:0]       wdata;
    logic [cx_pkg::XLEN-1:0]       exp_rdata;
  } row_t;

  logic clk_i;
  logic rst_ni;
  logic cmd_valid_i, cmd_ready_o, result_valid_o, busy_o;
  logic cx_req_valid_o, cx_req_ready_i, cx_resp_valid_i, cx_resp_ready_o;
  logic [cx_pkg::CX_FUNC_W-1:0]   cmd_func_i, cx_func_o;
  logic [cx_pkg::XLEN-1:0]        cmd_data0_i, cmd_data1_i, result_data_o;
  logic [cx_pkg::XLEN-1:0]        cx_req_data0_o, cx_req_data1_o, cx_resp_data_i;
  logic [cx_pkg::CX_ID_W-1:0]     cx_cxu_id_o, cx_state_id_o, cx_virt_state_id_o;
  logic [cx_pkg::CX_STATUS_W-1:0] cx_resp_status_i;
  logic                           csr_access_i;
  cx_pkg::csr_op_e                csr_op_i;
  logic [cx_pkg::CSR_ADDR_W-1:0]  csr_addr_i;
  logic [cx_pkg::XLEN-1:0]        csr_wdata_i, csr_rdata_o;

  row_t rows[$];
  int   seed = 87756;
  int   errors = 0;
  int   pulse_cnt = 0;
  int   num_cmds = 0;

  tb_clk_gen u_clk_gen (.clk_o(clk_i), .rst_no(rst_ni));

  cx_unit_top dut0 (.*);

  // Result pulses seen at the falling edge
  always @(negedge clk_i) begin
    if (rst_ni && result_valid_o) pulse_cnt++;
  end

  function automatic void add_cmd(input logic [24:0] func, input logic [31:0] d0,
                                  input logic [31:0] d1, input logic [3:0] status,
                                  input int req_dly, input int resp_dly);
    row_t r;
    r = '{is_csr: 1'b0, func: func, d0: d0, d1: d1, status: status, req_dly: req_dly,
          resp_dly: resp_dly, op: cx_pkg::CSR_READ, addr: '0, wdata: '0, exp_rdata: '0};
    rows.push_back(r);
  endfunction

  function automatic void add_csr(input cx_pkg::csr_op_e op, input logic [11:0] addr,
                                  input logic [31:0] wdata, input logic [31:0] exp_rdata);
    row_t r;
    r = '{is_csr: 1'b1, func: '0, d0: '0, d1: '0, status: '0, req_dly: 0, resp_dly: 0,
          op: op, addr: addr, wdata: wdata, exp_rdata: exp_rdata};
    rows.push_back(r);
  endfunction

  function automatic int pick_delay(input int dly);
    int d;
    d = (dly == 'hFF) ? ($unsigned($random(seed)) % 8) : dly;
    return d;
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("Fail %0t ns: %s is %h, expected %h", $time, what, got, exp);
  endtask

  task automatic abort_on_timeout(input string what);
    errors++;
    $display("Timeout at %0t ns while waiting for %s", $time, what);
    $display("Errors: %0d", errors);
    $display("TESTS FAILED");
    $finish;
  endtask

  // Checks while a request is pending
  task automatic check_pending(input row_t r);
    if (cx_req_valid_o !== 1'b1) report_mismatch("cx_req_valid_o", cx_req_valid_o, 1);
    if (cx_func_o !== r.func) report_mismatch("cx_func_o", cx_func_o, r.func);
    if (cx_req_data0_o !== r.d0) report_mismatch("cx_req_data0_o", cx_req_data0_o, r.d0);
    if (cx_req_data1_o !== r.d1) report_mismatch("cx_req_data1_o", cx_req_data1_o, r.d1);
    if (cmd_ready_o !== 1'b0) report_mismatch("cmd_ready_o", cmd_ready_o, 0);
    if (busy_o !== 1'b1) report_mismatch("busy_o", busy_o, 1);
  endtask

  task automatic run_cmd(input row_t r);
    int cnt;
    int dly;
    int k;
    int pulses_before;
    logic [cx_pkg::XLEN-1:0]      exp_data;
    logic [cx_pkg::CX_FUNC_W-1:0] cap_func;
    logic [cx_pkg::XLEN-1:0]      cap_d0;
    logic [cx_pkg::XLEN-1:0]      cap_d1;
    exp_data = r.d0 + r.d1 + {7'b0, r.func};
    pulses_before = pulse_cnt;
    @(posedge clk_i);
    cmd_valid_i <= 1'b1;
    cmd_func_i  <= r.func;
    cmd_data0_i <= r.d0;
    cmd_data1_i <= r.d1;
    cnt = 0;
    do begin
      @(negedge clk_i);
      cnt++;
    end while (!cmd_ready_o && cnt < TIMEOUT);
    if (!cmd_ready_o) abort_on_timeout("cmd_ready_o");
    @(posedge clk_i);
    // Scramble the inputs after acceptance to prove the payload was latched
    cmd_valid_i <= 1'b0;
    cmd_func_i  <= ~r.func;
    cmd_data0_i <= ~r.d0;
    cmd_data1_i <= ~r.d1;
    cnt = 0;
    do begin
      @(negedge clk_i);
      cnt++;
    end while (!cx_req_valid_o && cnt < TIMEOUT);
    if (!cx_req_valid_o) abort_on_timeout("cx_req_valid_o");
    dly = pick_delay(r.req_dly);
    for (k = 0; k <= dly; k++) begin
      if (k > 0) @(negedge clk_i);
      check_pending(r);
    end
    @(posedge clk_i);
    cx_req_ready_i <= 1'b1;
    @(negedge clk_i);
    check_pending(r);
    cap_func = cx_func_o;
    cap_d0   = cx_req_data0_o;
    cap_d1   = cx_req_data1_o;
    @(posedge clk_i);
    cx_req_ready_i <= 1'b0;

    ////////////////////////////////////////////////////////////////////////////
    // Response phase
    ////////////////////////////////////////////////////////////////////////////
    cnt = 0;
    do begin
      @(negedge clk_i);
      cnt++;
    end while (!cx_resp_ready_o && cnt < TIMEOUT);
    if (!cx_resp_ready_o) abort_on_timeout("cx_resp_ready_o");
    dly = pick_delay(r.resp_dly);
    for (k = 0; k <= dly; k++) begin
      if (k > 0) @(negedge clk_i);
      if (cx_resp_ready_o !== 1'b1) report_mismatch("cx_resp_ready_o", cx_resp_ready_o, 1);
      if (cmd_ready_o !== 1'b0) report_mismatch("cmd_ready_o", cmd_ready_o, 0);
      if (busy_o !== 1'b1) report_mismatch("busy_o", busy_o, 1);
    end
    @(posedge clk_i);
    cx_resp_valid_i  <= 1'b1;
    cx_resp_status_i <= r.status;
    cx_resp_data_i   <= cap_d0 + cap_d1 + {7'b0, cap_func};
    @(posedge clk_i);
    cx_resp_valid_i  <= 1'b0;
    cx_resp_status_i <= '0;
    cx_resp_data_i   <= '0;
    cnt = 0;
    do begin
      @(negedge clk_i);
      cnt++;
    end while (!result_valid_o && cnt < TIMEOUT);
    if (!result_valid_o) abort_on_timeout("result_valid_o");
    if (result_data_o !== exp_data) report_mismatch("result_data_o", result_data_o, exp_data);
    if (cmd_ready_o !== 1'b1) report_mismatch("cmd_ready_o after result", cmd_ready_o, 1);
    if (busy_o !== 1'b0) report_mismatch("busy_o after result", busy_o, 0);
    // Counter has seen the falling edge after the pulse by the next rising edge
    @(negedge clk_i);
    @(posedge clk_i);
    if (pulse_cnt != pulses_before + 1) begin
      report_mismatch("result pulse count", pulse_cnt, pulses_before + 1);
    end
  endtask

  task automatic run_csr(input row_t r);
    @(posedge clk_i);
    csr_access_i <= 1'b1;
    csr_op_i     <= r.op;
    csr_addr_i   <= r.addr;
    csr_wdata_i  <= r.wdata;
    @(negedge clk_i);
    if (csr_rdata_o !== r.exp_rdata) report_mismatch("csr_rdata_o", csr_rdata_o, r.exp_rdata);
    // Selector outputs must match the register fields
    if (r.op == cx_pkg::CSR_READ && r.addr == cx_pkg::CSR_MCX_SELECTOR) begin
      if (cx_cxu_id_o !== r.exp_rdata[1:0]) begin
        report_mismatch("cx_cxu_id_o", cx_cxu_id_o, r.exp_rdata[1:0]);
      end
      if (cx_state_id_o !== r.exp_rdata[3:2]) begin
        report_mismatch("cx_state_id_o", cx_state_id_o, r.exp_rdata[3:2]);
      end
      if (cx_virt_state_id_o !== r.exp_rdata[5:4]) begin
        report_mismatch("cx_virt_state_id_o", cx_virt_state_id_o, r.exp_rdata[5:4]);
      end
    end
    @(posedge clk_i);
    csr_access_i <= 1'b0;
    csr_op_i     <= cx_pkg::CSR_READ;
  endtask

  //////////////////////////////////////////////////////////////////////////////
  // Stimulus table and main sequence
  //////////////////////////////////////////////////////////////////////////////

  initial begin
    int cnt;
    cmd_valid_i      = 1'b0;
    cmd_func_i       = '0;
    cmd_data0_i      = '0;
    cmd_data1_i      = '0;
    cx_req_ready_i   = 1'b0;
    cx_resp_valid_i  = 1'b0;
    cx_resp_status_i = '0;
    cx_resp_data_i   = '0;
    csr_access_i     = 1'b0;
    csr_op_i         = cx_pkg::CSR_READ;
    csr_addr_i       = '0;
    csr_wdata_i      = '0;

    add_csr(cx_pkg::CSR_READ,  cx_pkg::CSR_MCX_SELECTOR, 32'h0, 32'h0);
    add_csr(cx_pkg::CSR_READ,  cx_pkg::CSR_MCX_STATUS,   32'h0, 32'h0);
    add_cmd(25'h0000123, 32'h0000_0010, 32'h0000_0020, 4'b0001, 0, 0);
    add_cmd(25'h1ABCDEF, 32'hFFFF_FFF0, 32'h1234_5678, 4'b0100, 3, 2);
    add_csr(cx_pkg::CSR_READ,  cx_pkg::CSR_MCX_STATUS,   32'h0, 32'h5);
    add_cmd(25'h0FF00FF, 32'h8000_0001, 32'h7FFF_FFFF, 4'b1000, 'hFF, 'hFF);
    add_csr(cx_pkg::CSR_READ,  cx_pkg::CSR_MCX_STATUS,   32'h0, 32'hD);
    add_csr(cx_pkg::CSR_CLEAR, cx_pkg::CSR_MCX_STATUS,   32'h4, 32'hD);
    add_csr(cx_pkg::CSR_READ,  cx_pkg::CSR_MCX_STATUS,   32'h0, 32'h9);
    add_csr(cx_pkg::CSR_SET,   cx_pkg::CSR_MCX_STATUS,   32'h2, 32'h9);
    add_csr(cx_pkg::CSR_READ,  cx_pkg::CSR_MCX_STATUS,   32'h0, 32'hB);
    add_csr(cx_pkg::CSR_WRITE, cx_pkg::CSR_MCX_STATUS,   32'h0, 32'hB);
    add_csr(cx_pkg::CSR_READ,  cx_pkg::CSR_MCX_STATUS,   32'h0, 32'h0);
    add_cmd(25'h1FFFFFF, 32'hA5A5_A5A5, 32'h5A5A_5A5A, 4'b0010, 1, 'hFF);
    add_csr(cx_pkg::CSR_READ,  cx_pkg::CSR_MCX_STATUS,   32'h0, 32'h2);
    add_csr(cx_pkg::CSR_WRITE, cx_pkg::CSR_MCX_SELECTOR, 32'h39, 32'h0);
    add_csr(cx_pkg::CSR_READ,  cx_pkg::CSR_MCX_SELECTOR, 32'h0, 32'h39);
    add_csr(cx_pkg::CSR_WRITE, cx_pkg::CSR_MCX_SELECTOR, 32'hFFFF_FFC6, 32'h39);
    add_csr(cx_pkg::CSR_READ,  cx_pkg::CSR_MCX_SELECTOR, 32'h0, 32'h06);
    add_csr(cx_pkg::CSR_WRITE, 12'h123,                  32'hFFFF_FFFF, 32'h0);
    add_csr(cx_pkg::CSR_READ,  12'h123,                  32'h0, 32'h0);
    add_csr(cx_pkg::CSR_READ,  cx_pkg::CSR_MCX_SELECTOR, 32'h0, 32'h06);
    add_csr(cx_pkg::CSR_READ,  cx_pkg::CSR_MCX_STATUS,   32'h0, 32'h2);

    cnt = 0;
    do begin
      @(negedge clk_i);
      cnt++;
    end while (!rst_ni && cnt < TIMEOUT);
    if (!rst_ni) abort_on_timeout("reset release");
    @(negedge clk_i);
    // Idle outputs right after reset
    if (cmd_ready_o !== 1'b1) report_mismatch("cmd_ready_o after reset", cmd_ready_o, 1);
    if (cx_req_valid_o !== 1'b0) report_mismatch("cx_req_valid_o", cx_req_valid_o, 0);
    if (cx_resp_ready_o !== 1'b0) report_mismatch("cx_resp_ready_o", cx_resp_ready_o, 0);
    if (result_valid_o !== 1'b0) report_mismatch("result_valid_o", result_valid_o, 0);
    if (busy_o !== 1'b0) report_mismatch("busy_o after reset", busy_o, 0);

    foreach (rows[i]) begin
      if (rows[i].is_csr) begin
        run_csr(rows[i]);
      end else begin
        run_cmd(rows[i]);
        num_cmds++;
      end
    end

    repeat (3) @(posedge clk_i);
    if (pulse_cnt != num_cmds) report_mismatch("total result pulses", pulse_cnt, num_cmds);

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
